//--- vliw_core.f
vliw_pkg.sv
gpr_file.sv
operand_bypass.sv
decode.sv
exec_unit.sv
vliw_core.sv
tb_clock.sv
tb_vliw_core.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then decide pass or fail from the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tb_vliw_core -f vliw_core.f \
    -o tb_vliw_core > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_vliw_core > sim.log 2>&1 \
    || { cat sim.log; echo "Run aborted"; exit 1; }
cat sim.log
grep -q "^Simulation passed$" sim.log \
    && echo "Result: PASS" \
    || { echo "Result: FAIL"; exit 1; }

//--- vliw_core_testdata.txt
// id   bundle            uv urt udata     lv lrt ldata
// id upper byte is the check group, group 05 is issued with no idle cycles
// Li and Liw, lower slot of Liw is the immediate
0201 482000644840FFFB 1 01 00000064 1 02 FFFFFFFB
0202 4C60000012345678 1 03 12345678 0 00 00000000
0203 4C80000080000001 1 04 80000001 0 00 00000000
0204 48A07FFF48C08000 1 05 00007FFF 1 06 FFFF8000
// Addi, Subi, Add, Sub with wrap
0301 00E1001005020005 1 07 00000074 1 08 FFFFFFF6
0302 092320000D411000 1 09 92345679 1 0A 00000069
0303 0964200001827FFF 1 0B 00000002 1 0C 00007FFA
0304 05A000010DC62800 1 0D FFFFFFFF 1 0E FFFF0001
// Srawi and Slawi, amount from the low 5 bits
0401 11E4000416010008 1 0F F8000000 1 10 00006400
0402 122300241645003F 1 11 01234567 1 12 80000000
0403 1266001F12850008 1 13 FFFFFFFF 1 14 0000007F
// Dependent bundles back to back
0501 4AA0000A4AC00003 1 15 0000000A 1 16 00000003
0502 0AF5B0000F15B000 1 17 0000000D 1 18 00000007
0503 0B37C00003550001 1 19 00000014 1 1A 0000000B
0504 4B6001114B600222 1 1B 00000111 1 1B 00000222
0505 039B00000FB9D000 1 1C 00000222 1 1D 00000009
0506 0BDBD8000BFCE800 1 1E 00000444 1 1F 0000022B
0507 02B5000106DE0044 1 15 0000000B 1 16 00000400
// Branch, load, FP and other opcodes write nothing
0601 4020000480410010 0 00 00000000 0 00 00000000
0602 FC60002AC0800000 0 00 00000000 0 00 00000000
0603 0121000001420000 1 09 00000064 1 0A FFFFFFFB
0604 0163000001840000 1 0B 12345678 1 0C 80000001
0605 482000557C200000 1 01 00000055 0 00 00000000
0606 0041000000610001 1 02 00000055 1 03 00000056

//--- tb_vliw_core.sv
`timescale 1ns/1ns

module tb_vliw_core;

    localparam int          MAX_REC     = 64;
    localparam int          REC_WORDS   = 8;
    localparam int          IDLE_CYCLES = 12;
    localparam int          TIMEOUT     = 100;
    localparam logic [7:0]  BURST_GROUP = 8'h05;
    localparam logic [31:0] SEED        = 32'd94883;

    logic          clk;
    logic          rstn;
    logic          inst_valid;
    logic [63:0]   inst;
    vliw_pkg::wb_t wb_u;
    vliw_pkg::wb_t wb_l;

    // Record: id, bundle, then valid, rt, data for upper and lower
    logic [63:0] tdata [0:MAX_REC*REC_WORDS-1];
    int          num_rec;
    int          cur_rec;
    logic [31:0] rng_state;

    // Issue tracking, lines up with the writeback two edges later
    logic        issue_p0;
    logic        issue_p1;
    int          rec_p0;
    int          rec_p1;

    int          checks_done;
    int          tests_run;
    int          tests_failed;
    int          error_count;

    tb_clock tb_clock_i (
        .clk  (clk),
        .rstn (rstn)
    );

    vliw_core vliw_core_i (
        .clk        (clk),
        .rstn       (rstn),
        .inst_valid (inst_valid),
        .inst       (inst),
        .wb_u       (wb_u),
        .wb_l       (wb_l)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic finish_test(input string label, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("Test %s ok", label);
        end else begin
            tests_failed++;
            $display("Test %s FAILED with %0d error(s)", label, errs);
        end
    endtask

    task automatic check_port(
        input  string         name,
        input  vliw_pkg::wb_t got,
        input  logic          exp_valid,
        input  logic [4:0]    exp_rt,
        input  logic [31:0]   exp_data,
        inout  int            errs
    );
        if (got.valid != exp_valid) begin
            $display("Error at %0t ns: %s.valid expected %0d got %0d",
                     $time, name, exp_valid, got.valid);
            errs++;
        end
        // rt and data only matter on a valid writeback
        if (exp_valid && got.rt != exp_rt) begin
            $display("Error at %0t ns: %s.rt expected %0d got %0d",
                     $time, name, exp_rt, got.rt);
            errs++;
        end
        if (exp_valid && got.data != exp_data) begin
            $display("Error at %0t ns: %s.data expected %h got %h",
                     $time, name, exp_data, got.data);
            errs++;
        end
    endtask

    task automatic check_record(input int r);
        int          base;
        int          errs;
        logic [15:0] test_id;

        base    = r * REC_WORDS;
        errs    = 0;
        test_id = tdata[base][15:0];
        check_port("wb_u", wb_u, tdata[base+2][0], tdata[base+3][4:0],
                   tdata[base+4][31:0], errs);
        check_port("wb_l", wb_l, tdata[base+5][0], tdata[base+6][4:0],
                   tdata[base+7][31:0], errs);
        error_count += errs;
        finish_test($sformatf("%h", test_id), errs);
        checks_done++;
    endtask

    // Idle cycles must never show a writeback
    task automatic check_quiet();
        if (wb_u.valid) begin
            $display("Error at %0t ns: wb_u.valid expected 0 got 1", $time);
            error_count++;
        end
        if (wb_l.valid) begin
            $display("Error at %0t ns: wb_l.valid expected 0 got 1", $time);
            error_count++;
        end
    endtask

    always @(posedge clk) begin
        issue_p0 <= inst_valid;
        rec_p0   <= cur_rec;
        issue_p1 <= issue_p0;
        rec_p1   <= rec_p0;
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rstn) begin
            if (issue_p1) begin
                check_record(rec_p1);
            end else begin
                check_quiet();
            end
        end
    end

    initial begin
        int          waited;
        int          gap;
        int          snap;
        int          r;
        logic [15:0] id;

        inst_valid   = 1'b0;
        inst         = '0;
        cur_rec      = 0;
        rng_state    = SEED;
        num_rec      = 0;
        checks_done  = 0;
        tests_run    = 0;
        tests_failed = 0;
        error_count  = 0;

        // Unused records keep an end marker in the upper word
        for (int a = 0; a < MAX_REC * REC_WORDS; a++) begin
            tdata[a] = {32'hffff_ffff, a};
        end
        $readmemh("vliw_core_testdata.txt", tdata);
        while (num_rec < MAX_REC && tdata[num_rec * REC_WORDS][63:32] != 32'hffff_ffff) begin
            num_rec++;
        end
        if (num_rec == 0) begin
            $display("No test records found in vliw_core_testdata.txt");
            error_count++;
        end
        for (r = 0; r < num_rec; r++) begin
            if (tdata[r * REC_WORDS + 3] >= 64'(vliw_pkg::NUM_GPR) ||
                tdata[r * REC_WORDS + 6] >= 64'(vliw_pkg::NUM_GPR)) begin
                $display("Data record %0d names a register that does not exist", r);
                error_count++;
            end
        end

        waited = 0;
        while (rstn !== 1'b1 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rstn !== 1'b1) begin
            $display("Reset was not released within %0d cycles", TIMEOUT);
            $display("Simulation failed");
            $finish;
        end else begin
            snap = error_count;
            repeat (IDLE_CYCLES) @(posedge clk);
            finish_test("idle", error_count - snap);

            for (r = 0; r < num_rec; r++) begin
                id        = tdata[r * REC_WORDS][15:0];
                rng_state = xorshift32(rng_state);
                // Forwarding group goes out back to back
                if (id[15:8] == BURST_GROUP) begin
                    gap = 0;
                end else begin
                    gap = {30'd0, rng_state[1:0]};
                end
                repeat (gap) begin
                    @(posedge clk);
                    inst_valid <= 1'b0;
                end
                @(posedge clk);
                inst_valid <= 1'b1;
                inst       <= tdata[r * REC_WORDS + 1];
                cur_rec    <= r;
            end
            @(posedge clk);
            inst_valid <= 1'b0;

            waited = 0;
            while (checks_done < num_rec && waited < TIMEOUT) begin
                @(posedge clk);
                waited++;
            end
            if (checks_done < num_rec) begin
                $display("Timed out with %0d of %0d bundles not checked",
                         num_rec - checks_done, num_rec);
                $display("Simulation failed");
                $finish;
            end else begin
                $display("Tests run %0d, failed %0d, errors %0d",
                         tests_run, tests_failed, error_count);
                if (tests_failed == 0 && error_count == 0) begin
                    $display("Simulation passed");
                end else begin
                    $display("Simulation failed");
                end
                $finish;
            end
        end
    end

endmodule

//--- tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rstn
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Released on a rising edge, the DUT reset is synchronous
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

//--- vliw_core.sv
`timescale 1ns/1ns

module vliw_core (
    input  logic          clk,
    input  logic          rstn,
    input  logic          inst_valid,
    input  logic [63:0]   inst,
    output vliw_pkg::wb_t wb_u,
    output vliw_pkg::wb_t wb_l
);

    // Per slot read index triples: ra, rb, rs
    logic [2:0][vliw_pkg::GPR_AW-1:0]                     rd_addr_u;
    logic [2:0][vliw_pkg::GPR_AW-1:0]                     rd_addr_l;
    logic [vliw_pkg::NUM_SRC-1:0][vliw_pkg::XLEN-1:0]     rf_data;
    logic [vliw_pkg::NUM_SRC-1:0][vliw_pkg::XLEN-1:0]     src_data;
    vliw_pkg::slot_op_t                                   op_u;
    vliw_pkg::slot_op_t                                   op_l;
    vliw_pkg::wb_t                                        fwd_u;
    vliw_pkg::wb_t                                        fwd_l;

    decode decode_i (
        .clk        (clk),
        .rstn       (rstn),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rd_addr    ({rd_addr_l, rd_addr_u}),
        .src_data   (src_data),
        .op_u       (op_u),
        .op_l       (op_l),
        .op_valid   ()
    );

    gpr_file gpr_file_i (
        .clk     (clk),
        .rstn    (rstn),
        .rd_addr ({rd_addr_l, rd_addr_u}),
        .rd_data (rf_data),
        .wb_u    (wb_u),
        .wb_l    (wb_l)
    );

    operand_bypass operand_bypass_i (
        .rd_addr  ({rd_addr_l, rd_addr_u}),
        .rf_data  (rf_data),
        .fwd_u    (fwd_u),
        .fwd_l    (fwd_l),
        .wb_u     (wb_u),
        .wb_l     (wb_l),
        .src_data (src_data)
    );

    exec_unit exec_u (
        .clk  (clk),
        .rstn (rstn),
        .op   (op_u),
        .fwd  (fwd_u),
        .wb   (wb_u)
    );

    exec_unit exec_l (
        .clk  (clk),
        .rstn (rstn),
        .op   (op_l),
        .fwd  (fwd_l),
        .wb   (wb_l)
    );

endmodule

//--- exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  logic               clk,
    input  logic               rstn,
    input  vliw_pkg::slot_op_t op,
    output vliw_pkg::wb_t      fwd,
    output vliw_pkg::wb_t      wb
);

    logic [vliw_pkg::XLEN-1:0] result;
    logic [4:0]                shamt;

    // Shift amount from the low bits of srcb only
    assign shamt = op.srcb[4:0];

    always_comb begin
        case (op.e_type)
            vliw_pkg::EAdd: begin
                result = op.srca + op.srcb;
            end
            vliw_pkg::ESub: begin
                result = op.srca - op.srcb;
            end
            vliw_pkg::ERshift: begin
                // Arithmetic, sign bit replicated
                result = $signed(op.srca) >>> shamt;
            end
            vliw_pkg::ELshift: begin
                result = op.srca << shamt;
            end
            vliw_pkg::EPass: begin
                result = op.srcb;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Result is visible to the bypass in the same cycle
    assign fwd = '{valid: op.rt_flag, rt: op.rt, data: result};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb <= '0;
        end else begin
            wb <= fwd;
        end
    end

endmodule

//--- decode.sv
`timescale 1ns/1ns

module decode (
    input  logic                                          clk,
    input  logic                                          rstn,
    input  logic                                          inst_valid,
    input  logic [63:0]                                   inst,
    output logic [vliw_pkg::NUM_SRC-1:0][vliw_pkg::GPR_AW-1:0] rd_addr,
    input  logic [vliw_pkg::NUM_SRC-1:0][vliw_pkg::XLEN-1:0]   src_data,
    output vliw_pkg::slot_op_t                            op_u,
    output vliw_pkg::slot_op_t                            op_l,
    output logic                                          op_valid
);

    logic [5:0]         opc_u;
    logic [5:0]         opc_l;
    vliw_pkg::dform_t   dform_u;
    vliw_pkg::dform_t   dform_l;
    vliw_pkg::xform_t   xform_u;
    vliw_pkg::xform_t   xform_l;
    logic               upper_liw;
    vliw_pkg::slot_op_t next_u;
    vliw_pkg::slot_op_t next_l;

    // Upper instruction in [63:32], lower in [31:0]
    assign opc_u   = inst[63:58];
    assign opc_l   = inst[31:26];
    assign dform_u = inst[57:32];
    assign dform_l = inst[25:0];
    assign xform_u = inst[57:32];
    assign xform_l = inst[25:0];

    assign upper_liw = (vliw_pkg::opcode_t'(opc_u) == vliw_pkg::Liw);

    // Operand indices, rs shares the rt field position
    always_comb begin
        rd_addr[vliw_pkg::SRC_UA] = dform_u.ra;
        rd_addr[vliw_pkg::SRC_UB] = xform_u.rb;
        rd_addr[vliw_pkg::SRC_US] = dform_u.rt;
        rd_addr[vliw_pkg::SRC_LA] = dform_l.ra;
        rd_addr[vliw_pkg::SRC_LB] = xform_l.rb;
        rd_addr[vliw_pkg::SRC_LS] = dform_l.rt;
    end

    function automatic vliw_pkg::slot_op_t decode_slot(
        input logic [5:0]                opc_bits,
        input vliw_pkg::dform_t          d,
        input logic [vliw_pkg::XLEN-1:0] ra_val,
        input logic [vliw_pkg::XLEN-1:0] rb_val,
        input logic [vliw_pkg::XLEN-1:0] imm_word
    );
        vliw_pkg::slot_op_t op;
        vliw_pkg::opcode_t  opc;

        opc       = vliw_pkg::opcode_t'(opc_bits);
        op.rt     = d.rt;
        op.srca   = ra_val;
        op.srcb   = {{16{d.si[15]}}, d.si};
        op.e_type = vliw_pkg::ENop;
        op.rt_flag = 1'b0;

        case (opc)
            vliw_pkg::Addi: begin
                op.e_type  = vliw_pkg::EAdd;
                op.rt_flag = 1'b1;
            end
            vliw_pkg::Subi: begin
                op.e_type  = vliw_pkg::ESub;
                op.rt_flag = 1'b1;
            end
            vliw_pkg::Add: begin
                op.e_type  = vliw_pkg::EAdd;
                op.srcb    = rb_val;
                op.rt_flag = 1'b1;
            end
            vliw_pkg::Sub: begin
                op.e_type  = vliw_pkg::ESub;
                op.srcb    = rb_val;
                op.rt_flag = 1'b1;
            end
            vliw_pkg::Srawi: begin
                op.e_type  = vliw_pkg::ERshift;
                op.rt_flag = 1'b1;
            end
            vliw_pkg::Slawi: begin
                op.e_type  = vliw_pkg::ELshift;
                op.rt_flag = 1'b1;
            end
            vliw_pkg::Li: begin
                op.e_type  = vliw_pkg::EPass;
                op.rt_flag = 1'b1;
            end
            vliw_pkg::Liw: begin
                op.e_type  = vliw_pkg::EPass;
                op.srcb    = imm_word;
                op.rt_flag = 1'b1;
            end
            default: begin
                op.e_type  = vliw_pkg::ENop;
                op.rt_flag = 1'b0;
            end
        endcase
        return op;
    endfunction

    always_comb begin
        next_u = decode_slot(opc_u, dform_u,
                             src_data[vliw_pkg::SRC_UA],
                             src_data[vliw_pkg::SRC_UB],
                             inst[31:0]);
        // No word follows the lower slot, so a stray Liw there acts like Li
        next_l = decode_slot(opc_l, dform_l,
                             src_data[vliw_pkg::SRC_LA],
                             src_data[vliw_pkg::SRC_LB],
                             {{16{dform_l.si[15]}}, dform_l.si});
        // Lower word is the Liw immediate
        if (upper_liw) begin
            next_l.e_type  = vliw_pkg::ENop;
            next_l.rt_flag = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            op_valid       <= 1'b0;
            op_u.e_type    <= vliw_pkg::ENop;
            op_u.rt_flag   <= 1'b0;
            op_l.e_type    <= vliw_pkg::ENop;
            op_l.rt_flag   <= 1'b0;
        end else if (inst_valid) begin
            op_valid <= 1'b1;
            op_u     <= next_u;
            op_l     <= next_l;
        end else begin
            // Bubble, operands keep their old values
            op_valid       <= 1'b0;
            op_u.e_type    <= vliw_pkg::ENop;
            op_u.rt_flag   <= 1'b0;
            op_l.e_type    <= vliw_pkg::ENop;
            op_l.rt_flag   <= 1'b0;
        end
    end

endmodule

//--- operand_bypass.sv
`timescale 1ns/1ns

module operand_bypass (
    input  logic [vliw_pkg::NUM_SRC-1:0][vliw_pkg::GPR_AW-1:0] rd_addr,
    input  logic [vliw_pkg::NUM_SRC-1:0][vliw_pkg::XLEN-1:0]   rf_data,
    input  vliw_pkg::wb_t                                 fwd_u,
    input  vliw_pkg::wb_t                                 fwd_l,
    input  vliw_pkg::wb_t                                 wb_u,
    input  vliw_pkg::wb_t                                 wb_l,
    output logic [vliw_pkg::NUM_SRC-1:0][vliw_pkg::XLEN-1:0]   src_data
);

    function automatic logic hit(
        input vliw_pkg::wb_t              w,
        input logic [vliw_pkg::GPR_AW-1:0] idx
    );
        return w.valid && (w.rt == idx);
    endfunction

    // Newest producer wins
    //   execute stage: lower then upper
    //   writeback stage: lower then upper
    //   register file last
    always_comb begin
        for (int i = 0; i < vliw_pkg::NUM_SRC; i++) begin
            if (hit(fwd_l, rd_addr[i])) begin
                src_data[i] = fwd_l.data;
            end else if (hit(fwd_u, rd_addr[i])) begin
                src_data[i] = fwd_u.data;
            end else if (hit(wb_l, rd_addr[i])) begin
                src_data[i] = wb_l.data;
            end else if (hit(wb_u, rd_addr[i])) begin
                src_data[i] = wb_u.data;
            end else begin
                src_data[i] = rf_data[i];
            end
        end
    end

endmodule

//--- gpr_file.sv
`timescale 1ns/1ns

module gpr_file (
    input  logic                                          clk,
    input  logic                                          rstn,
    input  logic [vliw_pkg::NUM_SRC-1:0][vliw_pkg::GPR_AW-1:0] rd_addr,
    output logic [vliw_pkg::NUM_SRC-1:0][vliw_pkg::XLEN-1:0]   rd_data,
    input  vliw_pkg::wb_t                                 wb_u,
    input  vliw_pkg::wb_t                                 wb_l
);

    logic [vliw_pkg::XLEN-1:0] regs [vliw_pkg::NUM_GPR];

    // Two write ports, lower slot is younger in program order
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < vliw_pkg::NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_u.valid) begin
                regs[wb_u.rt] <= wb_u.data;
            end
            // Applied last so it overrides the upper write
            if (wb_l.valid) begin
                regs[wb_l.rt] <= wb_l.data;
            end
        end
    end

    // Plain asynchronous reads, forwarding is handled outside
    always_comb begin
        for (int i = 0; i < vliw_pkg::NUM_SRC; i++) begin
            rd_data[i] = regs[rd_addr[i]];
        end
    end

endmodule

//--- vliw_pkg.sv
package vliw_pkg;

    // Machine widths
    localparam int XLEN    = 32;
    localparam int GPR_AW  = 5;
    localparam int NUM_GPR = 32;

    // Six operand read ports, three per slot
    localparam int NUM_SRC = 6;
    localparam int SRC_UA  = 0;
    localparam int SRC_UB  = 1;
    localparam int SRC_US  = 2;
    localparam int SRC_LA  = 3;
    localparam int SRC_LB  = 4;
    localparam int SRC_LS  = 5;

    // Integer opcodes handled by this datapath
    // FP, load/store, branch and I/O values fall to the no-op path
    typedef enum logic [5:0] {
        Addi  = 6'd0,
        Subi  = 6'd1,
        Add   = 6'd2,
        Sub   = 6'd3,
        Srawi = 6'd4,
        Slawi = 6'd5,
        Li    = 6'd18,
        Liw   = 6'd19
    } opcode_t;

    typedef enum logic [3:0] {
        ENop    = 4'd0,
        EAdd    = 4'd1,
        ESub    = 4'd2,
        ERshift = 4'd3,
        ELshift = 4'd4,
        EPass   = 4'd5
    } exec_type_t;

    // Immediate form
    typedef struct packed {
        logic [GPR_AW-1:0] rt;
        logic [GPR_AW-1:0] ra;
        logic [15:0]       si;
    } dform_t;

    // Register form
    typedef struct packed {
        logic [GPR_AW-1:0] rt;
        logic [GPR_AW-1:0] ra;
        logic [GPR_AW-1:0] rb;
        logic [10:0]       unused;
    } xform_t;

    // One decoded slot, operands already resolved
    typedef struct packed {
        exec_type_t        e_type;
        logic [GPR_AW-1:0] rt;
        logic              rt_flag;
        logic [XLEN-1:0]   srca;
        logic [XLEN-1:0]   srcb;
    } slot_op_t;

    typedef struct packed {
        logic              valid;
        logic [GPR_AW-1:0] rt;
        logic [XLEN-1:0]   data;
    } wb_t;

endpackage
